/* Makefile */
# Verilator build and run for the luminance DCT

VERILATOR ?= verilator
TOP       ?= tb_y_dct
FLIST     ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
DATA      ?= test/dct_input.txt
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

run: $(BIN) $(DATA)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/dct_block_seq.sv */
// ----------------------------------------
// DCT block sequencer
// Pixel column and row position inside
// the current 8x8 block
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dct_block_seq (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          enable,
	output logic [dct_fmt_pkg::idx_w-1:0] col_idx,
	output logic [dct_fmt_pkg::idx_w-1:0] row_idx,
	output logic                          row_last
);

	// ----------------------------------------
	// Position counters
	// ----------------------------------------

	// Both indices describe the pixel on data_in this cycle
	// A low enable returns the block to its first pixel,
	// so a broken block is never continued
	always_ff @(posedge clk) begin
		if (rst) begin
			col_idx <= '0;
			row_idx <= '0;
		end else if (!enable) begin
			col_idx <= '0;
			row_idx <= '0;
		end else begin
			// Column wraps every 8 pixels
			col_idx <= col_idx + 1'b1;
			// Row steps on the column wrap
			// and wraps itself at the block boundary
			if (row_last)
				row_idx <= row_idx + 1'b1;
		end
	end

	// ----------------------------------------
	// Boundary marks
	// ----------------------------------------

	// Column 7 is the all-ones index since blk_n is a power of two
	assign row_last = &col_idx;

endmodule

`default_nettype wire

/* hw/dct_coef_pkg.sv */
// ----------------------------------------
// DCT cosine table
// 8x8 forward DCT-II basis in Q14 form
// ----------------------------------------
`default_nettype none

package dct_coef_pkg;

	// Basis magnitudes, 2^14 times the orthonormal values
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c0 = 5793;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c1 = 8035;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c2 = 7568;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c3 = 6811;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c5 = 4551;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c6 = 3135;
	localparam logic signed [dct_fmt_pkg::coef_w-1:0] c7 = 1598;

	// Coefficient for frequency u at sample x
	function automatic logic signed [dct_fmt_pkg::coef_w-1:0] cos_coef(
		input logic [dct_fmt_pkg::idx_w-1:0] u,
		input logic [dct_fmt_pkg::idx_w-1:0] x
	);
		logic [6:0] phase;
		logic [4:0] k;
		logic [4:0] m;
		logic       neg;
		logic signed [dct_fmt_pkg::coef_w-1:0] mag;
		// Angle (2x+1)u in units of pi/16, one full turn is 32
		phase = {3'b000, x, 1'b1} * {4'b0000, u};
		k = phase[4:0];
		// Cosine is even, fold the lower half turn onto 0..16
		if (k > 5'd16)
			k = 5'd0 - k;
		// Second quadrant turns negative
		neg = (k > 5'd8);
		m = neg ? (5'd16 - k) : k;
		case (m)
			5'd0, 5'd4: mag = c0;
			5'd1:       mag = c1;
			5'd2:       mag = c2;
			5'd3:       mag = c3;
			5'd5:       mag = c5;
			5'd6:       mag = c6;
			5'd7:       mag = c7;
			default:    mag = '0;
		endcase
		return neg ? -mag : mag;
	endfunction

endpackage

`default_nettype wire

/* hw/dct_col_stage.sv */
// ----------------------------------------
// DCT column pass
// 64 accumulators, rounding to 11 bits
// and the coefficient output bank
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dct_col_stage (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                enable,
	input  logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::row_res_w-1:0] row_res,
	input  logic                                                row_valid,
	input  logic [dct_fmt_pkg::idx_w-1:0]                       row_num,
	output logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::blk_n*dct_fmt_pkg::out_w-1:0] coef,
	output logic                                                output_enable
);

	// Products and sums indexed [v][u]
	logic signed [dct_fmt_pkg::col_acc_w-1:0] prod_d [dct_fmt_pkg::blk_n][dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::col_acc_w-1:0] prod_q [dct_fmt_pkg::blk_n][dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::col_acc_w-1:0] acc [dct_fmt_pkg::blk_n][dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::col_acc_w-1:0] sum [dct_fmt_pkg::blk_n][dct_fmt_pkg::blk_n];
	logic                                     prod_vld;
	logic                                     prod_first;
	logic                                     prod_last;
	// One flag per row already taken for this block
	logic [dct_fmt_pkg::blk_n-1:0]            rows_seen;
	// Enable delayed by the three row pass cycles
	logic [2:0]                               en_dly;

	// ----------------------------------------
	// Multiply by the column basis
	// ----------------------------------------
	always_comb begin
		logic signed [dct_fmt_pkg::col_acc_w-1:0] res_ext;
		logic signed [dct_fmt_pkg::coef_w-1:0]    cf;
		logic signed [dct_fmt_pkg::col_acc_w-1:0] cf_ext;
		for (int u = 0; u < dct_fmt_pkg::blk_n; u++) begin
			res_ext = {{(dct_fmt_pkg::col_acc_w-dct_fmt_pkg::row_res_w)
				{row_res[u*dct_fmt_pkg::row_res_w+dct_fmt_pkg::row_res_w-1]}},
				row_res[u*dct_fmt_pkg::row_res_w +: dct_fmt_pkg::row_res_w]};
			for (int v = 0; v < dct_fmt_pkg::blk_n; v++) begin
				cf = dct_coef_pkg::cos_coef(v[dct_fmt_pkg::idx_w-1:0], row_num);
				cf_ext = {{(dct_fmt_pkg::col_acc_w-dct_fmt_pkg::coef_w){cf[dct_fmt_pkg::coef_w-1]}}, cf};
				prod_d[v][u] = res_ext * cf_ext;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (row_valid) begin
			prod_q     <= prod_d;
			prod_first <= (row_num == '0);
		end
	end

	// ----------------------------------------
	// Accumulate, reload on row 0
	// ----------------------------------------
	always_comb begin
		for (int v = 0; v < dct_fmt_pkg::blk_n; v++)
			for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
				sum[v][u] = acc[v][u] + prod_q[v][u];
	end

	always_ff @(posedge clk) begin
		if (prod_vld)
			for (int v = 0; v < dct_fmt_pkg::blk_n; v++)
				for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
					acc[v][u] <= prod_first ? prod_q[v][u] : sum[v][u];
	end

	// Row 7 rounds straight from the final sum into the bank
	always_ff @(posedge clk) begin
		if (rst)
			coef <= '0;
		else if (prod_last)
			for (int v = 0; v < dct_fmt_pkg::blk_n; v++)
				for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
					coef[(v*dct_fmt_pkg::blk_n+u)*dct_fmt_pkg::out_w +: dct_fmt_pkg::out_w] <=
						sum[v][u][dct_fmt_pkg::col_frac +: dct_fmt_pkg::out_w] +
						{{(dct_fmt_pkg::out_w-1){1'b0}}, sum[v][u][dct_fmt_pkg::col_frac-1]};
	end

	// ----------------------------------------
	// Block tracking
	// ----------------------------------------

	// Delayed enable lines up with row_valid, so a gap after a
	// finished block leaves its last row alone but an abort wipes the flags
	always_ff @(posedge clk) begin
		if (rst) begin
			en_dly        <= '0;
			rows_seen     <= '0;
			prod_vld      <= 1'b0;
			prod_last     <= 1'b0;
			output_enable <= 1'b0;
		end else begin
			en_dly        <= {en_dly[1:0], enable};
			prod_vld      <= row_valid;
			prod_last     <= row_valid && (&row_num) && (&rows_seen[dct_fmt_pkg::blk_n-2:0]);
			output_enable <= prod_last;
			if (!en_dly[2])
				rows_seen <= '0;
			else if (row_valid && row_num == '0)
				rows_seen <= {{(dct_fmt_pkg::blk_n-1){1'b0}}, 1'b1};
			else if (row_valid)
				rows_seen[row_num] <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/dct_fmt_pkg.sv */
// ----------------------------------------
// DCT number formats
// Fixed-point widths, rounding points and
// block geometry of the luminance DCT
// ----------------------------------------
`default_nettype none

package dct_fmt_pkg;

	// ----------------------------------------
	// Block geometry
	// ----------------------------------------
	localparam int pixel_w = 8;
	localparam int blk_n   = 8;
	localparam int idx_w   = 3;

	// Signed cosine coefficient, 14 fraction bits plus sign
	localparam int coef_w = 15;

	// ----------------------------------------
	// Row pass format
	// ----------------------------------------
	localparam int row_acc_w = 25;
	localparam int row_frac  = 12;
	localparam int row_res_w = 13;

	// ----------------------------------------
	// Column pass format
	// ----------------------------------------
	localparam int col_acc_w = 27;
	localparam int col_frac  = 16;
	localparam int out_w     = 11;

	// Level shift folded into the DC lane
	// 8 pixels of 128 times the DC coefficient 5793
	localparam logic signed [row_acc_w-1:0] dc_bias = 5932032;

	// Cycles from the last pixel of a block to output_enable
	localparam int pipe_lat = 5;

endpackage

`default_nettype wire

/* hw/dct_row_stage.sv */
// ----------------------------------------
// DCT row pass
// Eight MAC lanes, DC level shift and
// rounding of each row result to 13 bits
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dct_row_stage (
	input  logic                                                clk,
	input  logic                                                rst,
	input  logic                                                enable,
	input  logic [dct_fmt_pkg::pixel_w-1:0]                     data_in,
	input  logic [dct_fmt_pkg::idx_w-1:0]                       col_idx,
	input  logic [dct_fmt_pkg::idx_w-1:0]                       row_idx,
	input  logic                                                row_last,
	output logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::row_res_w-1:0] row_res,
	output logic                                                row_valid,
	output logic [dct_fmt_pkg::idx_w-1:0]                       row_num
);

	// Pixel and its eight basis values
	logic [dct_fmt_pkg::pixel_w-1:0]                pix_q;
	logic signed [dct_fmt_pkg::coef_w-1:0]          cq [dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::row_acc_w-1:0]       prod [dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::row_acc_w-1:0]       acc [dct_fmt_pkg::blk_n];
	logic signed [dct_fmt_pkg::row_acc_w-1:0]       cen [dct_fmt_pkg::blk_n];
	// Delay line flags
	logic                                           s1_vld;
	logic                                           s1_first;
	logic                                           s1_last;
	logic [dct_fmt_pkg::idx_w-1:0]                  s1_row;
	logic                                           s2_last;
	logic [dct_fmt_pkg::idx_w-1:0]                  s2_row;

	// ----------------------------------------
	// Input register
	// ----------------------------------------
	always_ff @(posedge clk) begin
		pix_q    <= data_in;
		s1_first <= (col_idx == '0);
		s1_row   <= row_idx;
		// Basis column for this sample position
		for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
			cq[u] <= dct_coef_pkg::cos_coef(u[dct_fmt_pkg::idx_w-1:0], col_idx);
	end

	// Unsigned pixel times signed coefficient
	always_comb begin
		logic signed [dct_fmt_pkg::row_acc_w-1:0] pix_ext;
		logic signed [dct_fmt_pkg::row_acc_w-1:0] cf_ext;
		pix_ext = {{(dct_fmt_pkg::row_acc_w-dct_fmt_pkg::pixel_w){1'b0}}, pix_q};
		for (int u = 0; u < dct_fmt_pkg::blk_n; u++) begin
			cf_ext = {{(dct_fmt_pkg::row_acc_w-dct_fmt_pkg::coef_w){cq[u][dct_fmt_pkg::coef_w-1]}},
				cq[u]};
			prod[u] = pix_ext * cf_ext;
		end
	end

	// ----------------------------------------
	// Accumulate, reload on column 0
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (s1_vld) begin
			for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
				acc[u] <= s1_first ? prod[u] : acc[u] + prod[u];
		end
		s2_row <= s1_row;
	end

	// Lane 0 alone carries the level shift of the 128 bias
	always_comb begin
		for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
			cen[u] = (u == 0) ? acc[u] - dct_fmt_pkg::dc_bias : acc[u];
	end

	// ----------------------------------------
	// Round and hold
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (s2_last) begin
			for (int u = 0; u < dct_fmt_pkg::blk_n; u++)
				row_res[u*dct_fmt_pkg::row_res_w +: dct_fmt_pkg::row_res_w] <=
					cen[u][dct_fmt_pkg::row_frac +: dct_fmt_pkg::row_res_w] +
					{{(dct_fmt_pkg::row_res_w-1){1'b0}}, cen[u][dct_fmt_pkg::row_frac-1]};
			row_num <= s2_row;
		end
	end

	// Valid flags
	// A cycle without enable never enters the pipe
	always_ff @(posedge clk) begin
		if (rst) begin
			s1_vld    <= 1'b0;
			s1_last   <= 1'b0;
			s2_last   <= 1'b0;
			row_valid <= 1'b0;
		end else begin
			s1_vld    <= enable;
			s1_last   <= enable && row_last;
			s2_last   <= s1_last;
			row_valid <= s2_last;
		end
	end

endmodule

`default_nettype wire

/* hw/y_dct.sv */
// ----------------------------------------
// Luminance 8x8 forward DCT
// Sequencer, row pass and column pass
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module y_dct (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       enable,
	input  logic [dct_fmt_pkg::pixel_w-1:0]            data_in,
	// Raster order, coefficient (v,u) at index v*8+u
	output logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::blk_n*dct_fmt_pkg::out_w-1:0] coef,
	output logic                                       output_enable
);

	// Position of the current pixel
	logic [dct_fmt_pkg::idx_w-1:0]                        col_idx;
	logic [dct_fmt_pkg::idx_w-1:0]                        row_idx;
	logic                                                 row_last;
	// Row pass results toward the column pass
	logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::row_res_w-1:0] row_res;
	logic                                                 row_valid;
	logic [dct_fmt_pkg::idx_w-1:0]                        row_num;

	dct_block_seq u_seq (
		.clk      (clk),
		.rst      (rst),
		.enable   (enable),
		.col_idx  (col_idx),
		.row_idx  (row_idx),
		.row_last (row_last)
	);

	// Three cycles from the last pixel of a row to row_valid
	dct_row_stage u_row (
		.clk       (clk),
		.rst       (rst),
		.enable    (enable),
		.data_in   (data_in),
		.col_idx   (col_idx),
		.row_idx   (row_idx),
		.row_last  (row_last),
		.row_res   (row_res),
		.row_valid (row_valid),
		.row_num   (row_num)
	);

	// Two more cycles to output_enable
	dct_col_stage u_col (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.row_res       (row_res),
		.row_valid     (row_valid),
		.row_num       (row_num),
		.coef          (coef),
		.output_enable (output_enable)
	);

endmodule

`default_nettype wire

/* sim.f */
hw/dct_fmt_pkg.sv
hw/dct_coef_pkg.sv
hw/dct_block_seq.sv
hw/dct_row_stage.sv
hw/dct_col_stage.sv
hw/y_dct.sv
test/y_dct_properties.sv
test/tb_y_dct.sv

/* test/dct_input.txt */
// Per block: 8 rows of 8 pixels (hex), then 8 rows of 8 expected coefficients
// Coefficients are 11-bit two's complement hex, row v, column u
// Block 0: flat 128
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
080 080 080 080 080 080 080 080
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
// Block 1: flat 255
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
0FF 0FF 0FF 0FF 0FF 0FF 0FF 0FF
3F8 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
// Block 2: diagonal ramp, 100 + 8*(x+y)
064 06C 074 07C 084 08C 094 09C
06C 074 07C 084 08C 094 09C 0A4
074 07C 084 08C 094 09C 0A4 0AC
07C 084 08C 094 09C 0A4 0AC 0B4
084 08C 094 09C 0A4 0AC 0B4 0BC
08C 094 09C 0A4 0AC 0B4 0BC 0C4
094 09C 0A4 0AC 0B4 0BC 0C4 0CC
09C 0A4 0AC 0B4 0BC 0C4 0CC 0D4
0E0 76E 000 7F0 000 7FC 000 7FF
76E 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
7F1 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
7FB 000 000 000 000 000 000 000
000 000 000 000 000 000 000 000
7FF 000 000 000 000 000 000 000

/* test/tb_y_dct.sv */
// ----------------------------------------
// Testbench for the luminance 8x8 DCT
// Feeds blocks from a data file and checks
// all 64 coefficients of every block
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_y_dct;

	localparam int n_blocks = 3;
	// Each block holds 64 pixels then 64 expected coefficients
	localparam int blk_words = 128;
	localparam int word_w = dct_fmt_pkg::out_w;
	localparam int max_wait = 200;

	logic clk;
	logic rst;
	logic enable;
	logic [dct_fmt_pkg::pixel_w-1:0] data_in;
	logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::blk_n*dct_fmt_pkg::out_w-1:0] coef;
	logic output_enable;

	logic [word_w-1:0] mem [0:n_blocks*blk_words-1];
	int exp_q[$];
	// Falling edge count at which each pulse is due
	int due_q[$];
	int errors;
	int checks;
	int pulses;
	int n_expected;
	int mon_blk;
	int mon_due;
	int cyc;

	y_dct dut (
		.clk           (clk),
		.rst           (rst),
		.enable        (enable),
		.data_in       (data_in),
		.coef          (coef),
		.output_enable (output_enable)
	);

	// ----------------------------------------
	// Clock
	// ----------------------------------------
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_value(input string name, input int got, input int exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	// Expected values are signed 11-bit words
	task automatic compare_block(input int b);
		int idx;
		for (int v = 0; v < dct_fmt_pkg::blk_n; v++) begin
			for (int u = 0; u < dct_fmt_pkg::blk_n; u++) begin
				idx = v * dct_fmt_pkg::blk_n + u;
				check_value($sformatf("coef[%0d][%0d]", v, u),
					int'($signed(coef[idx*dct_fmt_pkg::out_w +: dct_fmt_pkg::out_w])),
					int'($signed(mem[b*blk_words+64+idx])));
			end
		end
	endtask

	// Drive the first npix pixels of block b in raster order
	task automatic feed_block(input int b, input int npix);
		for (int i = 0; i < npix; i++) begin
			@(posedge clk);
			enable  <= 1'b1;
			data_in <= mem[b*blk_words+i][dct_fmt_pkg::pixel_w-1:0];
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			enable <= 1'b0;
		end
	endtask

	task automatic send_block(input int b, input int gap);
		feed_block(b, 64);
		exp_q.push_back(b);
		// Last pixel is on data_in until the falling edge numbered cyc + 1
		due_q.push_back(cyc + 1 + dct_fmt_pkg::pipe_lat);
		n_expected++;
		idle(gap);
	endtask

	task automatic wait_pulses;
		int cnt;
		cnt = 0;
		while (pulses < n_expected && cnt < max_wait) begin
			@(posedge clk);
			cnt++;
		end
		if (pulses < n_expected) begin
			errors++;
			$display("Timeout at %0t: output_enable pulse did not arrive", $time);
		end
	endtask

	// ----------------------------------------
	// Output monitor on the falling edge
	// ----------------------------------------
	always @(negedge clk) begin
		cyc++;
		if (!rst) begin
			if (output_enable) begin
				pulses++;
				if (exp_q.size() == 0) begin
					errors++;
					$display("Unexpected output_enable pulse at %0t with no block sent", $time);
				end else begin
					mon_blk = exp_q.pop_front();
					mon_due = due_q.pop_front();
					check_value("output_enable cycle", cyc, mon_due);
					compare_block(mon_blk);
				end
			end else if (pulses == 0) begin
				check_value("coef before first block", int'(|coef), 0);
			end
		end
	end

	// ----------------------------------------
	// Stimulus
	// ----------------------------------------
	initial begin
		rst        = 1'b1;
		enable     = 1'b0;
		data_in    = '0;
		errors     = 0;
		checks     = 0;
		pulses     = 0;
		n_expected = 0;
		cyc        = 0;
		void'($urandom(99269));
		$readmemh("test/dct_input.txt", mem);
		if (^mem[n_blocks*blk_words-1] === 1'bx) begin
			errors++;
			$display("Data file test/dct_input.txt could not be read");
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		idle(10);

		// Flat block then bright and ramp blocks back to back
		send_block(0, 1);
		wait_pulses();
		send_block(1, $urandom_range(0, 7));
		send_block(2, 1 + $urandom_range(0, 6));
		wait_pulses();

		// Random order with random idle gaps
		for (int i = 0; i < 6; i++)
			send_block($urandom_range(0, n_blocks - 1), $urandom_range(0, 7));
		idle(1);
		wait_pulses();

		// Abort after 20 pixels and expect no pulse
		feed_block(2, 20);
		idle(12);
		check_value("pulses after abort", pulses, n_expected);
		send_block(2, 1);
		wait_pulses();
		idle(4);

		$display("Errors: %0d in %0d checks, %0d pulses", errors, checks, pulses);
		if (errors == 0 && pulses == n_expected) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* test/y_dct_properties.sv */
// ----------------------------------------
// DCT output properties
// Pulse shape and coefficient hold
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module y_dct_properties (
	input logic                                                              clk,
	input logic                                                              rst,
	input logic [dct_fmt_pkg::blk_n*dct_fmt_pkg::blk_n*dct_fmt_pkg::out_w-1:0] coef,
	input logic                                                              output_enable
);

	// One cycle pulse only
	single_pulse: assert property (@(posedge clk) disable iff (rst)
		output_enable |=> !output_enable)
		else $error("output_enable high for two cycles");

	// Bank changes only together with the pulse
	coef_hold: assert property (@(posedge clk) disable iff (rst)
		!output_enable |-> $stable(coef))
		else $error("coef changed without output_enable");

	// Reset clears the output side
	reset_quiet: assert property (@(posedge clk)
		rst |=> (!output_enable && coef == '0))
		else $error("output not cleared by reset");

endmodule

bind y_dct y_dct_properties props (
	.clk           (clk),
	.rst           (rst),
	.coef          (coef),
	.output_enable (output_enable)
);

`default_nettype wire
